/* logic/fabric_pkg.sv */
package fabric_pkg;

  // widths are fixed by the line frame and the bus
  localparam int addr_w = 8;
  localparam int data_w = 8;
  localparam int id_w   = 2;

  localparam int num_slaves = 3;

  // 3-bit line patterns, oldest sample in the msb
  localparam logic [2:0] frame_start   = 3'b111;
  localparam logic [2:0] frame_confirm = 3'b101;
  localparam logic [2:0] frame_cancel  = 3'b110;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // 0 = no slave, 1..3 select a slave
  typedef logic [id_w-1:0] slave_id_t;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_M1,
    OWN_M2
  } owner_t;

endpackage : fabric_pkg

/* logic/line_if.sv */
`timescale 1ns/1ps

// events from one master's line decoder, grant back from the arbiter
interface line_if;

  logic                  req;          // one cycle, after second id bit
  fabric_pkg::slave_id_t slave_id;     // valid with req
  logic                  confirm;
  logic                  cancel;
  logic                  release_bus;
  logic                  grant;        // level

  modport decoder (
    output req, slave_id, confirm, cancel, release_bus,
    input  grant
  );

  modport arbiter (
    input  req, slave_id, confirm, cancel, release_bus,
    output grant
  );

endinterface : line_if

/* logic/line_decoder.sv */
`timescale 1ns/1ps

module line_decoder (
  input  logic   clk,
  input  logic   rstn,
  input  logic   line,
  line_if.decoder ev
);

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_ID,
    LD_WAIT,
    LD_XFER
  } ld_state_t;

  ld_state_t  state;
  logic [2:0] hist;   // last three samples, newest in bit 0
  logic [1:0] gcnt;   // samples taken under grant, saturates at 2
  logic [2:0] win;    // window including the sample taken this edge
  logic [1:0] id_now; // both id bits as seen on the second id edge

  assign win    = {hist[1:0], line};
  assign id_now = {hist[0], line};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state          <= LD_IDLE;
      hist           <= '0;
      gcnt           <= '0;
      ev.req         <= 1'b0;
      ev.confirm     <= 1'b0;
      ev.cancel      <= 1'b0;
      ev.release_bus <= 1'b0;
    end else begin
      hist           <= {hist[1:0], line};
      ev.req         <= 1'b0; // all events are single-cycle pulses
      ev.confirm     <= 1'b0;
      ev.cancel      <= 1'b0;
      ev.release_bus <= 1'b0;

      case (state)
        LD_IDLE: begin
          gcnt <= '0;
          // three ones already sampled, this edge takes the first id bit
          if (hist == fabric_pkg::frame_start) state <= LD_ID;
        end

        LD_ID: begin
          ev.req <= 1'b1;
          // id 0 is never granted, so don't wait for it
          state  <= (id_now == '0) ? LD_IDLE : LD_WAIT;
        end

        LD_WAIT: begin
          if (!ev.grant) begin
            if (gcnt != '0) state <= LD_IDLE; // grant taken away
          end else if (gcnt != 2'd2) begin
            gcnt <= gcnt + 2'd1;
          end else if (win == fabric_pkg::frame_confirm) begin
            ev.confirm <= 1'b1;
            state      <= LD_XFER;
          end else if (win == fabric_pkg::frame_cancel) begin
            ev.cancel <= 1'b1;
            state     <= LD_IDLE;
          end
        end

        LD_XFER: begin
          if (!ev.grant) begin
            state <= LD_IDLE;
          end else if (hist[1:0] == 2'b10) begin // line fell last edge
            ev.release_bus <= 1'b1;
            state          <= LD_IDLE;
          end
        end

        default: state <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LD_ID) ev.slave_id <= id_now;
  end

  // the arbiter keeps grant up through the cycle of any event
  a_event_under_grant: assert property (
    @(posedge clk) disable iff (!rstn)
      (ev.confirm || ev.cancel || ev.release_bus) |-> ev.grant
  ) else $error("line event seen without grant");

endmodule : line_decoder

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic               clk,
  input  logic               rstn,
  line_if.arbiter            m1,
  line_if.arbiter            m2,
  output logic               m1_com,
  output logic               m2_com,
  output fabric_pkg::owner_t owner,
  output fabric_pkg::slave_id_t sel_slave
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_GRANT,
    ARB_XFER
  } arb_state_t;

  arb_state_t state;

  logic                  m1_pend;
  logic                  m2_pend;
  fabric_pkg::slave_id_t m1_id;
  fabric_pkg::slave_id_t m2_id;

  logic set_m1;
  logic set_m2;
  logic take_m1;
  logic take_m2;
  logic own_confirm;
  logic own_cancel;
  logic own_release;

  // id 0 dropped, and the owner can't queue behind itself
  assign set_m1 = m1.req && (m1.slave_id != '0) && (owner != fabric_pkg::OWN_M1);
  assign set_m2 = m2.req && (m2.slave_id != '0) && (owner != fabric_pkg::OWN_M2);

  // fixed priority, master 1 first
  assign take_m1 = (state == ARB_IDLE) && m1_pend;
  assign take_m2 = (state == ARB_IDLE) && m2_pend && !m1_pend;

  // only the owner's events count
  assign own_confirm = (owner == fabric_pkg::OWN_M1 && m1.confirm) ||
                       (owner == fabric_pkg::OWN_M2 && m2.confirm);
  assign own_cancel  = (owner == fabric_pkg::OWN_M1 && m1.cancel) ||
                       (owner == fabric_pkg::OWN_M2 && m2.cancel);
  assign own_release = (owner == fabric_pkg::OWN_M1 && m1.release_bus) ||
                       (owner == fabric_pkg::OWN_M2 && m2.release_bus);

  assign m1.grant = (owner == fabric_pkg::OWN_M1);
  assign m2.grant = (owner == fabric_pkg::OWN_M2);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m1_pend <= 1'b0;
      m2_pend <= 1'b0;
    end else begin
      if (take_m1)     m1_pend <= 1'b0;
      else if (set_m1) m1_pend <= 1'b1;
      if (take_m2)     m2_pend <= 1'b0;
      else if (set_m2) m2_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (set_m1) m1_id <= m1.slave_id;
    if (set_m2) m2_id <= m2.slave_id;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= ARB_IDLE;
      owner     <= fabric_pkg::OWN_NONE;
      sel_slave <= '0;
      m1_com    <= 1'b0;
      m2_com    <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (take_m1) begin
            state     <= ARB_GRANT;
            owner     <= fabric_pkg::OWN_M1;
            sel_slave <= m1_id;
          end else if (take_m2) begin
            state     <= ARB_GRANT;
            owner     <= fabric_pkg::OWN_M2;
            sel_slave <= m2_id;
          end
        end

        ARB_GRANT: begin
          if (own_confirm) begin
            state  <= ARB_XFER;
            m1_com <= (owner == fabric_pkg::OWN_M1);
            m2_com <= (owner == fabric_pkg::OWN_M2);
          end else if (own_cancel) begin
            state     <= ARB_IDLE; // declined, nothing transferred
            owner     <= fabric_pkg::OWN_NONE;
            sel_slave <= '0;
          end
        end

        ARB_XFER: begin
          if (own_release) begin
            state     <= ARB_IDLE;
            owner     <= fabric_pkg::OWN_NONE;
            sel_slave <= '0;
            m1_com    <= 1'b0;
            m2_com    <= 1'b0;
          end
        end

        default: state <= ARB_IDLE;
      endcase
    end
  end

  // a granted master always has a real slave behind it
  a_grant_has_slave: assert property (
    @(posedge clk) disable iff (!rstn) (m1.grant || m2.grant) |-> (sel_slave != '0)
  ) else $error("grant without a selected slave");

  a_com_needs_grant: assert property (
    @(posedge clk) disable iff (!rstn) (m1_com |-> m1.grant) and (m2_com |-> m2.grant)
  ) else $error("com level without grant");

endmodule : bus_arbiter

/* logic/bus_mux.sv */
`timescale 1ns/1ps

module bus_mux (
  input  fabric_pkg::owner_t    owner,
  input  fabric_pkg::slave_id_t sel_slave,
  input  fabric_pkg::addr_t     m1_addr,
  input  fabric_pkg::addr_t     m2_addr,
  input  fabric_pkg::data_t     m1_wdata,
  input  fabric_pkg::data_t     m2_wdata,
  input  logic                  m1_valid,
  input  logic                  m2_valid,
  input  logic                  m1_last,
  input  logic                  m2_last,
  output fabric_pkg::data_t     m1_rdata,
  output fabric_pkg::data_t     m2_rdata,
  output logic                  m1_ready,
  output logic                  m2_ready,
  output fabric_pkg::addr_t     s_addr,
  output fabric_pkg::data_t     s_wdata,
  output logic                  s_last,
  output logic                  s_valid [fabric_pkg::num_slaves],
  input  fabric_pkg::data_t     s_rdata [fabric_pkg::num_slaves],
  input  logic                  s_ready [fabric_pkg::num_slaves]
);

  logic              own_valid;
  fabric_pkg::data_t sel_rdata;
  logic              sel_ready;

  always_comb begin
    s_addr    = m1_addr;
    s_wdata   = m1_wdata;
    s_last    = m1_last;
    own_valid = 1'b0; // no owner, no valid
    case (owner)
      fabric_pkg::OWN_M1: begin
        own_valid = m1_valid;
      end
      fabric_pkg::OWN_M2: begin
        s_addr    = m2_addr;
        s_wdata   = m2_wdata;
        s_last    = m2_last;
        own_valid = m2_valid;
      end
      default: ;
    endcase

    sel_rdata = '0;
    sel_ready = 1'b0;
    for (int i = 0; i < fabric_pkg::num_slaves; i++) begin
      // slave id i+1 sits at index i
      s_valid[i] = own_valid && (sel_slave == fabric_pkg::slave_id_t'(i + 1));
      if (sel_slave == fabric_pkg::slave_id_t'(i + 1)) begin
        sel_rdata = s_rdata[i];
        sel_ready = s_ready[i];
      end
    end

    m1_rdata = (owner == fabric_pkg::OWN_M1) ? sel_rdata : '0;
    m2_rdata = (owner == fabric_pkg::OWN_M2) ? sel_rdata : '0;
    m1_ready = (owner == fabric_pkg::OWN_M1) && sel_ready; // non-owner held off
    m2_ready = (owner == fabric_pkg::OWN_M2) && sel_ready;
  end

endmodule : bus_mux

/* logic/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric (
  input  logic              clk,
  input  logic              rstn,
  input  logic              m1_line,
  input  logic              m2_line,
  output logic              m1_gnt,
  output logic              m2_gnt,
  output logic              m1_com,
  output logic              m2_com,
  input  fabric_pkg::addr_t m1_addr,
  input  fabric_pkg::addr_t m2_addr,
  input  fabric_pkg::data_t m1_wdata,
  input  fabric_pkg::data_t m2_wdata,
  input  logic              m1_valid,
  input  logic              m2_valid,
  input  logic              m1_last,
  input  logic              m2_last,
  output fabric_pkg::data_t m1_rdata,
  output fabric_pkg::data_t m2_rdata,
  output logic              m1_ready,
  output logic              m2_ready,
  output fabric_pkg::addr_t s_addr,
  output fabric_pkg::data_t s_wdata,
  output logic              s_last,
  output logic              s_valid [fabric_pkg::num_slaves],
  input  fabric_pkg::data_t s_rdata [fabric_pkg::num_slaves],
  input  logic              s_ready [fabric_pkg::num_slaves]
);

  fabric_pkg::owner_t    owner;
  fabric_pkg::slave_id_t sel_slave;

  line_if m1_if ();
  line_if m2_if ();

  assign m1_gnt = m1_if.grant;
  assign m2_gnt = m2_if.grant;

  line_decoder dec_m1_i (.clk(clk), .rstn(rstn), .line(m1_line), .ev(m1_if.decoder));
  line_decoder dec_m2_i (.clk(clk), .rstn(rstn), .line(m2_line), .ev(m2_if.decoder));

  bus_arbiter arb_i (
    .clk(clk), .rstn(rstn),
    .m1(m1_if.arbiter), .m2(m2_if.arbiter),
    .m1_com(m1_com), .m2_com(m2_com),
    .owner(owner), .sel_slave(sel_slave)
  );

  bus_mux mux_i (
    .owner(owner), .sel_slave(sel_slave),
    .m1_addr(m1_addr), .m2_addr(m2_addr),
    .m1_wdata(m1_wdata), .m2_wdata(m2_wdata),
    .m1_valid(m1_valid), .m2_valid(m2_valid),
    .m1_last(m1_last), .m2_last(m2_last),
    .m1_rdata(m1_rdata), .m2_rdata(m2_rdata),
    .m1_ready(m1_ready), .m2_ready(m2_ready),
    .s_addr(s_addr), .s_wdata(s_wdata), .s_last(s_last),
    .s_valid(s_valid), .s_rdata(s_rdata), .s_ready(s_ready)
  );

endmodule : bus_fabric

/* verification/bus_fabric_tb.sv */
`timescale 1ns/1ps

module bus_fabric_tb;

  localparam int n_items    = 30;
  localparam int period     = 100;
  localparam int wait_limit = 12; // cycles allowed for any grant or com change

  logic              clk;
  logic              rstn;
  logic [2:1]        line_v;
  logic [2:1]        valid_v;
  logic [2:1]        last_v;
  logic [2:1][7:0]   addr_v;
  logic [2:1][7:0]   wdata_v;
  logic [2:1][7:0]   rdata_v;
  logic [2:1]        gnt_v;
  logic [2:1]        com_v;
  logic [2:1]        ready_v;
  fabric_pkg::addr_t s_addr;
  fabric_pkg::data_t s_wdata;
  logic              s_last;
  logic              s_valid [fabric_pkg::num_slaves];
  fabric_pkg::data_t s_rdata [fabric_pkg::num_slaves];
  logic              s_ready [fabric_pkg::num_slaves];

  logic [15:0]           lfsr;
  logic [2:1]            pend;          // model of the arbiter's pending flags
  fabric_pkg::slave_id_t pend_id [1:2];

  bus_fabric dut_i (
    .clk(clk), .rstn(rstn),
    .m1_line(line_v[1]), .m2_line(line_v[2]),
    .m1_gnt(gnt_v[1]), .m2_gnt(gnt_v[2]), .m1_com(com_v[1]), .m2_com(com_v[2]),
    .m1_addr(addr_v[1]), .m2_addr(addr_v[2]),
    .m1_wdata(wdata_v[1]), .m2_wdata(wdata_v[2]),
    .m1_valid(valid_v[1]), .m2_valid(valid_v[2]),
    .m1_last(last_v[1]), .m2_last(last_v[2]),
    .m1_rdata(rdata_v[1]), .m2_rdata(rdata_v[2]),
    .m1_ready(ready_v[1]), .m2_ready(ready_v[2]),
    .s_addr(s_addr), .s_wdata(s_wdata), .s_last(s_last),
    .s_valid(s_valid), .s_rdata(s_rdata), .s_ready(s_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // x^16 + x^15 + x^13 + x^4 + 1, one step per bit
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic fabric_pkg::slave_id_t pick_id();
    logic [7:0] r;
    r = take_bits(4);
    return fabric_pkg::slave_id_t'(r % 8'd3 + 8'd1); // 1..3 only
  endfunction

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
      stop_run();
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  // who = 0 sends on both lines in the same cycles
  task automatic send_frames(input int who, input fabric_pkg::slave_id_t id1,
                             input fabric_pkg::slave_id_t id2);
    logic [2:1][4:0] f;
    f[1] = {fabric_pkg::frame_start, id1};
    f[2] = {fabric_pkg::frame_start, id2};
    for (int b = 4; b >= 0; b--) begin
      for (int k = 1; k <= 2; k++) begin
        if (who == 0 || who == k) line_v[k] = f[k][b]; // msb first
      end
      tick();
    end
    line_v = '0;
    for (int k = 1; k <= 2; k++) begin
      if ((who == 0 || who == k) && f[k][1:0] != '0) begin // id 0 is dropped
        pend[k]    = 1'b1;
        pend_id[k] = f[k][1:0];
      end
    end
  endtask

  task automatic wait_level(input int m, input logic use_com, input logic level,
                            input logic com_low);
    int n;
    n = 0;
    while ((use_com ? com_v[m] : gnt_v[m]) !== level) begin
      if (n == wait_limit) begin
        $display("m%0d %s did not reach %0b within %0d cycles", m,
                 use_com ? "com" : "gnt", level, wait_limit);
        stop_run();
      end
      tick();
      n++;
      check($sformatf("m%0d_gnt", 3 - m), {7'd0, gnt_v[3 - m]}, 8'h00);
      if (com_low) check($sformatf("m%0d_com", m), {7'd0, com_v[m]}, 8'h00);
    end
  endtask

  task automatic check_idle();
    #40; // mid-cycle
    for (int k = 1; k <= 2; k++) begin
      check($sformatf("m%0d_gnt", k), {7'd0, gnt_v[k]}, 8'h00);
      check($sformatf("m%0d_com", k), {7'd0, com_v[k]}, 8'h00);
      check($sformatf("m%0d_ready", k), {7'd0, ready_v[k]}, 8'h00);
    end
    for (int i = 0; i < fabric_pkg::num_slaves; i++) begin
      check($sformatf("s_valid[%0d]", i), {7'd0, s_valid[i]}, 8'h00);
    end
  endtask

  // serves whichever pending master the model says wins next
  task automatic serve_next();
    int                    m;
    int                    o;
    int                    sel;
    int                    hold;
    logic                  accept;
    logic [2:0]            pat;
    fabric_pkg::slave_id_t id;
    m       = pend[1] ? 1 : 2; // master 1 first
    o       = 3 - m;
    id      = pend_id[m];
    sel     = int'(id) - 1;    // slave id 1..3 at index 0..2
    pend[m] = 1'b0;
    accept  = take_bits(1) != '0;
    hold    = int'(take_bits(3)) + 1;
    wait_level(m, 1'b0, 1'b1, 1'b1);
    pat = accept ? fabric_pkg::frame_confirm : fabric_pkg::frame_cancel;
    for (int b = 2; b >= 0; b--) begin
      line_v[m] = pat[b];
      tick();
    end
    if (accept) begin
      wait_level(m, 1'b1, 1'b1, 1'b0); // line stays high while owning
      repeat (hold) begin
        check($sformatf("m%0d_com", m), {7'd0, com_v[m]}, 8'h01);
        for (int k = 1; k <= 2; k++) begin
          addr_v[k]  = take_bits(8);
          wdata_v[k] = take_bits(8);
          valid_v[k] = take_bits(1) != '0;
          last_v[k]  = take_bits(1) != '0;
        end
        for (int i = 0; i < fabric_pkg::num_slaves; i++) begin
          s_rdata[i] = take_bits(8);
          s_ready[i] = take_bits(1) != '0;
        end
        #40;
        check("s_addr", s_addr, addr_v[m]);
        check("s_wdata", s_wdata, wdata_v[m]);
        check("s_last", {7'd0, s_last}, {7'd0, last_v[m]});
        for (int i = 0; i < fabric_pkg::num_slaves; i++) begin
          check($sformatf("s_valid[%0d]", i), {7'd0, s_valid[i]},
                {7'd0, valid_v[m] && i == sel});
        end
        check($sformatf("m%0d_rdata", m), rdata_v[m], s_rdata[sel]);
        check($sformatf("m%0d_ready", m), {7'd0, ready_v[m]}, {7'd0, s_ready[sel]});
        check($sformatf("m%0d_rdata", o), rdata_v[o], 8'h00); // non-owner sees nothing
        check($sformatf("m%0d_ready", o), {7'd0, ready_v[o]}, 8'h00);
        tick();
      end
      line_v[m] = 1'b0; // falling edge ends the transfer
      wait_level(m, 1'b0, 1'b0, 1'b0);
      check($sformatf("m%0d_com", m), {7'd0, com_v[m]}, 8'h00);
    end else begin
      wait_level(m, 1'b0, 1'b0, 1'b1);
    end
  endtask

  initial begin
    #((n_items * 200 + 100) * period);
    $display("watchdog expired before the tests finished");
    stop_run();
  end

  initial begin
    int                    m;
    logic [1:0]            kind;
    fabric_pkg::slave_id_t id;
    lfsr    = 16'd63291;
    rstn    = 1'b0;
    line_v  = '0;
    valid_v = '0;
    last_v  = '0;
    addr_v  = '0;
    wdata_v = '0;
    pend    = '0;
    for (int i = 0; i < fabric_pkg::num_slaves; i++) begin
      s_rdata[i] = '0;
      s_ready[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    #10;
    rstn = 1'b1;
    check_idle();
    tick();

    for (int item = 0; item < n_items; item++) begin
      kind = 2'(take_bits(2));
      m    = int'(take_bits(1)) + 1;
      if (kind == 2'd0) begin
        send_frames(m, '0, '0);
        repeat (8) begin // no grant may follow an id 0 frame
          tick();
          check("m1_gnt", {7'd0, gnt_v[1]}, 8'h00);
          check("m2_gnt", {7'd0, gnt_v[2]}, 8'h00);
        end
      end else if (kind == 2'd1) begin
        send_frames(0, pick_id(), pick_id());
        serve_next();
        serve_next();
      end else begin
        id = pick_id();
        send_frames(m, id, id);
        serve_next();
      end
      check_idle();
      tick();
    end

    $display("Done: no errors");
    $finish;
  end

endmodule : bus_fabric_tb

/* bus_fabric.f */
logic/fabric_pkg.sv
logic/line_if.sv
logic/line_decoder.sv
logic/bus_arbiter.sv
logic/bus_mux.sv
logic/bus_fabric.sv
verification/bus_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module bus_fabric_tb \
  -f bus_fabric.f -o bus_fabric_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/bus_fabric_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
